/* flowPkg.sv */
package flowPkg;

	// Top-level controller states.
	// IDLE waits for enable, LOAD_COEFF streams the kernel into the FIR,
	// RUN moves samples and FLUSH clears the tap lines before going idle.
	typedef enum logic [1:0] {
		IDLE,
		LOAD_COEFF,
		RUN,
		FLUSH
	} ctrlState;

	// Phases of a four-phase req/ack handshake, seen from the DUT side.
	// REQ_WAIT is the quiet phase, ACK_HIGH holds the acknowledge (or the request).
	// REQ_LOW waits for the far side to finish the return to zero.
	typedef enum logic [1:0] {
		REQ_WAIT,
		ACK_HIGH,
		REQ_LOW
	} hsPhase;

endpackage

/* groupDelay.sv */
module groupDelay import hilbertPkg::*; #(
	parameter int LENGTH = 27,
	parameter int DATA_WIDTH = 18
) (
	input logic clock,
	input logic rstN,
	input logic sampleStart,
	input logic signed [DATA_WIDTH-1:0] sampleIn,
	input logic clearTaps,
	output logic signed [accWidth(DATA_WIDTH)-1:0] delayedOut
);

	// Group delay of the odd-length Hilbert FIR, in samples.
	localparam int DELAY = (LENGTH - 1) / 2;
	localparam int AW = accWidth(DATA_WIDTH);

	// delayLine[i] is the sample taken i samples ago.
	logic signed [DATA_WIDTH-1:0] delayLine [DELAY + 1];

	// Oldest sample, sign-extended to the output width.
	logic signed [AW-1:0] extended;

	// The line counts samples, not clock cycles, so it moves only on sampleStart.
	always_ff @(posedge clock) begin
		if (!rstN || clearTaps) begin
			for (int i = 0; i <= DELAY; i++) begin
				delayLine[i] <= '0;
			end
		end else if (sampleStart) begin
			delayLine[0] <= sampleIn;
			for (int i = 1; i <= DELAY; i++) begin
				delayLine[i] <= delayLine[i - 1];
			end
		end
	end

	assign extended = {{(AW - DATA_WIDTH){delayLine[DELAY][DATA_WIDTH-1]}}, delayLine[DELAY]};

	// Move the binary point to COEFF_FRAC so the real part lines up with the FIR sum.
	// It is valid the cycle after sampleStart and holds until the next sample.
	assign delayedOut = extended <<< COEFF_FRAC;

endmodule

/* hilbertPkg.sv */
package hilbertPkg;

	// Number of fractional bits in every Hilbert coefficient.
	// Both outputs carry the same binary point.
	localparam int COEFF_FRAC = 15;

	// Default width of one signed input sample.
	localparam int SAMPLE_WIDTH = 18;

	// Pi, used only while the coefficient table is built at elaboration.
	localparam real PI = 3.14159265358979323846;

	// One signed input sample at the default width.
	typedef logic signed [SAMPLE_WIDTH-1:0] sampleT;

	// Width of the real and imaginary outputs.
	// It is the full width of a sample times coefficient product.
	function automatic int accWidth(input int dataWidth);
		return 2 * dataWidth;
	endfunction

	// Ideal Hilbert kernel, tap by tap, in fixed point with COEFF_FRAC fraction bits.
	// The centre of the odd-length kernel sits at tap (length-1)/2.
	// Even offsets from the centre, the centre included, are zero.
	function automatic int htCoeff(input int tap, input int length);
		int k;
		real scaled;
		k = tap - (length - 1) / 2;
		if (k % 2 == 0) begin
			return 0;
		end
		scaled = (2.0 ** COEFF_FRAC) * 2.0 / (PI * k);
		// Round half away from zero, since $rtoi truncates toward zero.
		if (scaled >= 0.0) begin
			return $rtoi(scaled + 0.5);
		end
		return $rtoi(scaled - 0.5);
	endfunction

endpackage

/* hilbertTransform.sv */
module hilbertTransform import hilbertPkg::*; #(
	parameter int LENGTH = 27,
	parameter int DATA_WIDTH = $bits(sampleT)
) (
	input logic clock,
	input logic rstN,
	input logic enable,
	input logic stop,
	input logic inReq,
	input logic signed [DATA_WIDTH-1:0] inData,
	input logic outAck,
	output logic inAck,
	output logic outReq,
	output logic signed [accWidth(DATA_WIDTH)-1:0] outRe,
	output logic signed [accWidth(DATA_WIDTH)-1:0] outIm,
	output logic ready
);

	localparam int AW = accWidth(DATA_WIDTH);

	// Coefficient stream from the generator to the FIR.
	logic coeffLoad;
	logic coeffValid;
	logic coeffDone;
	logic signed [DATA_WIDTH-1:0] coeffValue;

	// Per-sample strobes and data shared by the FIR and the real-path delay.
	logic sampleStart;
	logic signed [DATA_WIDTH-1:0] sampleIn;
	logic clearTaps;

	// Results returning to the controller.
	logic firDone;
	logic signed [AW-1:0] firOut;
	logic signed [AW-1:0] delayedOut;

	htControl #(
		.LENGTH(LENGTH),
		.DATA_WIDTH(DATA_WIDTH)
	) u_control (
		.clock(clock),
		.rstN(rstN),
		.enable(enable),
		.stop(stop),
		.inReq(inReq),
		.inData(inData),
		.outAck(outAck),
		.coeffDone(coeffDone),
		.firDone(firDone),
		.firOut(firOut),
		.delayedOut(delayedOut),
		.inAck(inAck),
		.outReq(outReq),
		.outRe(outRe),
		.outIm(outIm),
		.ready(ready),
		.coeffLoad(coeffLoad),
		.sampleStart(sampleStart),
		.sampleIn(sampleIn),
		.clearTaps(clearTaps)
	);

	htCoeffGen #(
		.LENGTH(LENGTH),
		.DATA_WIDTH(DATA_WIDTH)
	) u_coeffGen (
		.clock(clock),
		.rstN(rstN),
		.coeffLoad(coeffLoad),
		.coeffValid(coeffValid),
		.coeffOut(coeffValue),
		.coeffDone(coeffDone)
	);

	// Imaginary path: the Hilbert FIR.
	serialFir #(
		.LENGTH(LENGTH),
		.DATA_WIDTH(DATA_WIDTH)
	) u_fir (
		.clock(clock),
		.rstN(rstN),
		.coeffValid(coeffValid),
		.coeffIn(coeffValue),
		.sampleStart(sampleStart),
		.sampleIn(sampleIn),
		.clearTaps(clearTaps),
		.firDone(firDone),
		.firOut(firOut)
	);

	// Real path: the same samples, delayed to match the FIR centre tap.
	groupDelay #(
		.LENGTH(LENGTH),
		.DATA_WIDTH(DATA_WIDTH)
	) u_delay (
		.clock(clock),
		.rstN(rstN),
		.sampleStart(sampleStart),
		.sampleIn(sampleIn),
		.clearTaps(clearTaps),
		.delayedOut(delayedOut)
	);

endmodule

/* htCoeffGen.sv */
module htCoeffGen import hilbertPkg::*; #(
	parameter int LENGTH = 27,
	parameter int DATA_WIDTH = 18
) (
	input logic clock,
	input logic rstN,
	input logic coeffLoad,
	output logic coeffValid,
	output logic signed [DATA_WIDTH-1:0] coeffOut,
	output logic coeffDone
);

	localparam int CW = $clog2(LENGTH);

	// The kernel is a constant table, built once at elaboration.
	logic signed [DATA_WIDTH-1:0] coeffTable [LENGTH];

	// Index of the coefficient presented in the current cycle.
	logic [CW-1:0] tapCount;

	for (genvar i = 0; i < LENGTH; i++) begin : gTable
		localparam int COEFF = htCoeff(i, LENGTH);
		assign coeffTable[i] = COEFF[DATA_WIDTH-1:0];
	end

	// The FIR shifts this value in whenever coeffValid is high.
	assign coeffOut = coeffTable[tapCount];

	// A load request starts a run of LENGTH valid cycles in index order.
	// The cycle after the last coefficient carries a single coeffDone.
	always_ff @(posedge clock) begin
		if (!rstN) begin
			coeffValid <= 1'b0;
			coeffDone <= 1'b0;
			tapCount <= '0;
		end else begin
			coeffDone <= 1'b0;
			if (coeffLoad) begin
				coeffValid <= 1'b1;
				tapCount <= '0;
			end else if (coeffValid) begin
				if (tapCount == CW'(LENGTH - 1)) begin
					coeffValid <= 1'b0;
					coeffDone <= 1'b1;
					tapCount <= '0;
				end else begin
					tapCount <= tapCount + 1'b1;
				end
			end
		end
	end

	// The controller asks for a new load only once the previous stream has ended.
	loadWhileIdle: assert property (@(posedge clock) disable iff (!rstN)
		coeffLoad |-> !coeffValid && !coeffDone);

endmodule

/* htControl.sv */
module htControl import hilbertPkg::*, flowPkg::*; #(
	parameter int LENGTH = 27,
	parameter int DATA_WIDTH = 18
) (
	input logic clock,
	input logic rstN,
	input logic enable,
	input logic stop,
	input logic inReq,
	input logic signed [DATA_WIDTH-1:0] inData,
	input logic outAck,
	input logic coeffDone,
	input logic firDone,
	input logic signed [accWidth(DATA_WIDTH)-1:0] firOut,
	input logic signed [accWidth(DATA_WIDTH)-1:0] delayedOut,
	output logic inAck,
	output logic outReq,
	output logic signed [accWidth(DATA_WIDTH)-1:0] outRe,
	output logic signed [accWidth(DATA_WIDTH)-1:0] outIm,
	output logic ready,
	output logic coeffLoad,
	output logic sampleStart,
	output logic signed [DATA_WIDTH-1:0] sampleIn,
	output logic clearTaps
);

	ctrlState state;
	hsPhase inPhase;
	hsPhase outPhase;

	// High from sampleStart until the sink has finished taking the result.
	logic inFlight;
	logic outIdle;
	logic acceptSample;
	logic stopNow;

	// The output channel is idle only when both wires are back to zero.
	assign outIdle = (outPhase == REQ_WAIT) && !outReq && !outAck;

	// Only one sample is in flight at a time.
	// A pending stop blocks new samples so the path drains first.
	assign acceptSample = (state == RUN) && (inPhase == REQ_WAIT) && inReq
		&& !inFlight && outIdle && !stop;

	assign stopNow = (state == RUN) && stop && !inFlight && (inPhase == REQ_WAIT);

	assign ready = (state == RUN);

	always_ff @(posedge clock) begin
		if (!rstN) begin
			state <= IDLE;
			inPhase <= REQ_WAIT;
			outPhase <= REQ_WAIT;
			inAck <= 1'b0;
			outReq <= 1'b0;
			inFlight <= 1'b0;
			coeffLoad <= 1'b0;
			sampleStart <= 1'b0;
			clearTaps <= 1'b0;
		end else begin
			// Strobes last a single cycle unless set again below.
			coeffLoad <= 1'b0;
			sampleStart <= 1'b0;
			clearTaps <= 1'b0;

			// Main sequence: load the kernel, run, then flush on stop.
			case (state)
				IDLE: begin
					if (enable && !stop) begin
						state <= LOAD_COEFF;
						coeffLoad <= 1'b1;
					end
				end
				LOAD_COEFF: begin
					if (coeffDone) begin
						state <= RUN;
					end
				end
				RUN: begin
					if (stopNow) begin
						state <= FLUSH;
						clearTaps <= 1'b1;
					end
				end
				FLUSH: begin
					state <= IDLE;
				end
				default: begin
					state <= IDLE;
				end
			endcase

			// Input channel. The acknowledge starts the sample through both stages.
			case (inPhase)
				REQ_WAIT: begin
					if (acceptSample) begin
						inAck <= 1'b1;
						sampleStart <= 1'b1;
						inFlight <= 1'b1;
						inPhase <= ACK_HIGH;
					end
				end
				ACK_HIGH: begin
					if (!inReq) begin
						inAck <= 1'b0;
						inPhase <= REQ_WAIT;
					end
				end
				default: begin
					inAck <= 1'b0;
					inPhase <= REQ_WAIT;
				end
			endcase

			// Output channel. The sample leaves flight once outAck has returned low.
			case (outPhase)
				REQ_WAIT: begin
					if (firDone) begin
						outReq <= 1'b1;
						outPhase <= ACK_HIGH;
					end
				end
				ACK_HIGH: begin
					if (outAck) begin
						outReq <= 1'b0;
						outPhase <= REQ_LOW;
					end
				end
				REQ_LOW: begin
					if (!outAck) begin
						inFlight <= 1'b0;
						outPhase <= REQ_WAIT;
					end
				end
				default: begin
					outReq <= 1'b0;
					outPhase <= REQ_WAIT;
				end
			endcase
		end
	end

	// Payload registers. The result is held for as long as outReq stays high.
	always_ff @(posedge clock) begin
		if (acceptSample) begin
			sampleIn <= inData;
		end
		if ((outPhase == REQ_WAIT) && firDone) begin
			outRe <= delayedOut;
			outIm <= firOut;
		end
	end

	// A new sample is acknowledged only on a live request and an idle output side.
	inAckOnReq: assert property (@(posedge clock) disable iff (!rstN)
		$rose(inAck) |-> $past(inReq && !outReq && !outAck));

	// The result is offered until the sink takes it.
	outReqHeld: assert property (@(posedge clock) disable iff (!rstN)
		outReq && !outAck |=> outReq);

	// The FIR result comes back a fixed LENGTH+1 cycles after the sample went in.
	firLatency: assert property (@(posedge clock) disable iff (!rstN)
		firDone |-> $past(sampleStart, LENGTH + 1));

endmodule

/* run.sh */
#!/usr/bin/env bash
# Builds the Hilbert transform testbench with Verilator and runs it.
# The result is taken from the simulation log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=simHilbert

rm -rf obj_dir "$LOG"

if ! verilator --binary --timing --assert -Wno-fatal \
	--top-module tbHilbert -o "$BIN" -f tb.f; then
	echo "Verilator build failed"
	exit 1
fi

if ! ./obj_dir/"$BIN" > "$LOG" 2>&1; then
	echo "Simulation exited with an error status"
fi

cat "$LOG"

if grep -q "TEST PASSED" "$LOG"; then
	echo "Simulation passed"
	exit 0
else
	echo "Simulation failed, see $LOG"
	exit 1
fi

/* serialFir.sv */
module serialFir import hilbertPkg::*; #(
	parameter int LENGTH = 27,
	parameter int DATA_WIDTH = 18
) (
	input logic clock,
	input logic rstN,
	input logic coeffValid,
	input logic signed [DATA_WIDTH-1:0] coeffIn,
	input logic sampleStart,
	input logic signed [DATA_WIDTH-1:0] sampleIn,
	input logic clearTaps,
	output logic firDone,
	output logic signed [accWidth(DATA_WIDTH)-1:0] firOut
);

	localparam int AW = accWidth(DATA_WIDTH);
	localparam int IW = $clog2(LENGTH);

	// coeffReg[i] holds kernel tap i once a full load has shifted through.
	logic signed [DATA_WIDTH-1:0] coeffReg [LENGTH];

	// tapReg[i] holds the sample taken i samples ago.
	logic signed [DATA_WIDTH-1:0] tapReg [LENGTH];

	// Accumulation state. One product is added per cycle while busy.
	logic busy;
	logic [IW-1:0] macIndex;
	logic signed [AW-1:0] acc;
	logic signed [AW-1:0] product;

	// Coefficients arrive in index order and enter at the top.
	// After LENGTH shifts the first one has reached position zero.
	always_ff @(posedge clock) begin
		if (coeffValid) begin
			for (int i = 0; i < LENGTH - 1; i++) begin
				coeffReg[i] <= coeffReg[i + 1];
			end
			coeffReg[LENGTH - 1] <= coeffIn;
		end
	end

	// The data line moves one place per accepted sample.
	// Both reset and a flush leave it at zero, which matches an empty history.
	always_ff @(posedge clock) begin
		if (!rstN || clearTaps) begin
			for (int i = 0; i < LENGTH; i++) begin
				tapReg[i] <= '0;
			end
		end else if (sampleStart) begin
			tapReg[0] <= sampleIn;
			for (int i = 1; i < LENGTH; i++) begin
				tapReg[i] <= tapReg[i - 1];
			end
		end
	end

	// Full-width signed product of one coefficient and its tap.
	assign product = coeffReg[macIndex] * tapReg[macIndex];

	// Sequencing of the serial MAC.
	// The last product lands together with firDone, LENGTH+1 cycles after sampleStart.
	always_ff @(posedge clock) begin
		if (!rstN) begin
			busy <= 1'b0;
			macIndex <= '0;
			firDone <= 1'b0;
		end else begin
			firDone <= 1'b0;
			if (sampleStart) begin
				busy <= 1'b1;
				macIndex <= '0;
			end else if (busy) begin
				if (macIndex == IW'(LENGTH - 1)) begin
					busy <= 1'b0;
					firDone <= 1'b1;
				end else begin
					macIndex <= macIndex + 1'b1;
				end
			end
		end
	end

	// The accumulator wraps at AW bits.
	// Stimulus amplitude is kept small enough that it never does.
	always_ff @(posedge clock) begin
		if (sampleStart) begin
			acc <= '0;
		end else if (busy) begin
			acc <= acc + product;
		end
	end

	// The sum stays put after firDone until the next sample starts.
	assign firOut = acc;

	// A new sample would corrupt the running sum.
	noStartWhileBusy: assert property (@(posedge clock) disable iff (!rstN)
		sampleStart |-> !busy);

endmodule

/* tb.f */
hilbertPkg.sv
flowPkg.sv
htCoeffGen.sv
serialFir.sv
groupDelay.sv
htControl.sv
hilbertTransform.sv
tbHilbert.sv

/* tbHilbert.sv */
module tbHilbert import hilbertPkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int LENGTH = 27;
	localparam int DATA_WIDTH = 18;
	localparam int AW = accWidth(DATA_WIDTH);
	localparam int DELAY = (LENGTH - 1) / 2;

	// The first run holds the impulse, the step and the random section.
	// The second run follows a stop and a reload.
	localparam int IMPULSE_LEN = LENGTH;
	localparam int STEP_LEN = 12;
	localparam int RANDOM_LEN = 40;
	localparam int FIRST_RUN = IMPULSE_LEN + STEP_LEN + RANDOM_LEN;
	localparam int SECOND_RUN = 12;
	localparam int NUM_ENTRIES = FIRST_RUN + SECOND_RUN;
	localparam int IMPULSE_AMP = 1024;
	localparam int STEP_AMP = 700;
	localparam int TIMEOUT_CYCLES = NUM_ENTRIES * (LENGTH + 20) + 300;

	// One row per input sample, with the sink delay and the expected pair.
	typedef struct {
		int sample;
		int ackDelay;
		longint expRe;
		longint expIm;
	} entryT;

	entryT stimTable [NUM_ENTRIES];

	// The clock starts at zero without an edge at time zero.
	logic clock = 1'b0;
	logic rstN;
	logic enable;
	logic stop;
	logic inReq;
	sampleT inData;
	logic outAck;
	logic inAck;
	logic outReq;
	logic signed [AW-1:0] outRe;
	logic signed [AW-1:0] outIm;
	logic ready;

	logic [31:0] rngState;
	int cycleCount;

	// Handshake history for the monitor, one cycle back.
	// outAck is taken at the rising edge, where the DUT samples it.
	logic lastInAck = 1'b0;
	logic lastOutReq = 1'b0;
	logic lastOutAck = 1'b0;

	hilbertTransform #(
		.LENGTH(LENGTH),
		.DATA_WIDTH(DATA_WIDTH)
	) u_dut (
		.clock(clock),
		.rstN(rstN),
		.enable(enable),
		.stop(stop),
		.inReq(inReq),
		.inData(inData),
		.outAck(outAck),
		.inAck(inAck),
		.outReq(outReq),
		.outRe(outRe),
		.outIm(outIm),
		.ready(ready)
	);

	initial begin
		forever #4 clock = ~clock;
	end

	// Compares one value and ends the run on the first mismatch.
	task automatic checkValue(input string name, input logic signed [63:0] expected,
		input logic signed [63:0] actual);
		if (expected !== actual) begin
			$display("CHECK FAILED at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
			$display("TEST FAILED");
			$fatal(1, "Value mismatch on %s", name);
		end
	endtask

	// 32-bit xorshift step.
	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Ideal Hilbert tap in Q15, worked out directly from 2/(pi*k).
	function automatic longint kernelTap(input int tap);
		int k;
		real v;
		k = tap - DELAY;
		if (k % 2 == 0) begin
			return 0;
		end
		v = 32768.0 * 2.0 / (3.14159265358979 * k);
		if (v >= 0.0) begin
			return longint'($rtoi(v + 0.5));
		end
		return longint'($rtoi(v - 0.5));
	endfunction

	// Fills the stimulus columns, then runs the reference model over them.
	// The model history starts empty, and again at the restart after stop.
	task automatic buildTable();
		longint history [LENGTH];
		longint sum;
		for (int i = 0; i < NUM_ENTRIES; i++) begin
			rngState = xorshift(rngState);
			stimTable[i].ackDelay = int'(rngState % 32'd6);
			if (i < IMPULSE_LEN) begin
				stimTable[i].sample = (i == 0) ? IMPULSE_AMP : 0;
			end else if (i < IMPULSE_LEN + STEP_LEN) begin
				stimTable[i].sample = STEP_AMP;
			end else begin
				rngState = xorshift(rngState);
				stimTable[i].sample = int'(rngState % 32'd2049) - 1024;
			end
		end
		for (int i = 0; i < NUM_ENTRIES; i++) begin
			if (i == 0 || i == FIRST_RUN) begin
				for (int j = 0; j < LENGTH; j++) begin
					history[j] = 0;
				end
			end
			for (int j = LENGTH - 1; j > 0; j--) begin
				history[j] = history[j - 1];
			end
			history[0] = stimTable[i].sample;
			sum = 0;
			for (int j = 0; j < LENGTH; j++) begin
				sum += kernelTap(j) * history[j];
			end
			stimTable[i].expIm = sum;
			stimTable[i].expRe = history[DELAY] * (longint'(1) << COEFF_FRAC);
		end
	endtask

	// Raises enable and counts clock edges until ready, the enabling edge included.
	task automatic enableAndLoad();
		int cycles;
		cycles = 0;
		@(negedge clock);
		enable = 1'b1;
		do begin
			@(posedge clock);
			cycles++;
			@(negedge clock);
		end while (!ready);
		checkValue("cycles from enable to ready", LENGTH + 3, cycles);
	endtask

	// Source side of the input four-phase channel.
	task automatic sendSamples(input int first, input int last);
		for (int i = first; i <= last; i++) begin
			@(negedge clock);
			inReq = 1'b1;
			inData = sampleT'(stimTable[i].sample);
			while (!inAck) @(negedge clock);
			inReq = 1'b0;
			while (inAck) @(negedge clock);
		end
	endtask

	// Sink side of the output channel. Each result is held back by the row's delay.
	task automatic receiveResults(input int first, input int last);
		logic signed [AW-1:0] heldRe;
		logic signed [AW-1:0] heldIm;
		for (int i = first; i <= last; i++) begin
			@(negedge clock);
			while (!outReq) @(negedge clock);
			heldRe = outRe;
			heldIm = outIm;
			checkValue("outRe", stimTable[i].expRe, heldRe);
			checkValue("outIm", stimTable[i].expIm, heldIm);
			// The impulse response is the kernel itself, scaled by the impulse height.
			if (i < IMPULSE_LEN) begin
				checkValue("outIm impulse", kernelTap(i) * IMPULSE_AMP, heldIm);
				checkValue("outRe impulse",
					(i == DELAY) ? (longint'(IMPULSE_AMP) << COEFF_FRAC) : 0, heldRe);
			end
			repeat (stimTable[i].ackDelay) begin
				@(negedge clock);
				checkValue("outReq held", 1, outReq);
				checkValue("outRe held", heldRe, outRe);
				checkValue("outIm held", heldIm, outIm);
			end
			outAck = 1'b1;
			while (outReq) @(negedge clock);
			outAck = 1'b0;
		end
	endtask

	// Drops enable and pulses stop once the last result has been taken.
	task automatic stopAndFlush();
		repeat (2) @(negedge clock);
		checkValue("ready before stop", 1, ready);
		enable = 1'b0;
		stop = 1'b1;
		@(negedge clock);
		checkValue("ready after stop", 0, ready);
		@(negedge clock);
		stop = 1'b0;
	endtask

	// A new input is only acknowledged once the output channel is back at rest.
	always @(negedge clock) begin
		if (inAck && !lastInAck) begin
			checkValue("outReq when inAck rose", 0, lastOutReq);
			checkValue("outAck when inAck rose", 0, lastOutAck);
		end
		lastInAck <= inAck;
		lastOutReq <= outReq;
	end

	always @(posedge clock) begin
		lastOutAck <= outAck;
	end

	// Watchdog sized from the table length.
	initial begin
		cycleCount = 0;
		while (cycleCount < TIMEOUT_CYCLES) begin
			@(posedge clock);
			cycleCount++;
		end
		$display("Timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
		$display("TEST FAILED");
		$fatal(1, "Simulation timed out");
	end

	initial begin
		rstN = 1'b0;
		enable = 1'b0;
		stop = 1'b0;
		inReq = 1'b0;
		inData = '0;
		outAck = 1'b0;
		rngState = 32'h385a_7eed;
		buildTable();

		repeat (2) @(negedge clock);
		rstN = 1'b1;
		@(negedge clock);
		checkValue("inAck after reset", 0, inAck);
		checkValue("outReq after reset", 0, outReq);
		checkValue("ready after reset", 0, ready);

		// First run: impulse, step and random samples.
		enableAndLoad();
		fork
			sendSamples(0, FIRST_RUN - 1);
			receiveResults(0, FIRST_RUN - 1);
		join

		// Second run starts from cleared taps after the reload.
		stopAndFlush();
		enableAndLoad();
		fork
			sendSamples(FIRST_RUN, NUM_ENTRIES - 1);
			receiveResults(FIRST_RUN, NUM_ENTRIES - 1);
		join

		repeat (4) @(negedge clock);
		checkValue("outReq at end", 0, outReq);
		checkValue("inAck at end", 0, inAck);
		$display("TEST PASSED");
		$finish;
	end

endmodule
